/* src/mmu_arb_defines.svh */
//====================
// field widths shared by the jTLB request arbiter
// include wherever a port or slice needs a width
//====================
`ifndef MMU_ARB_DEFINES_SVH
`define MMU_ARB_DEFINES_SVH

// virtual page number, 39-bit VA minus 4K offset
`define ARB_VPN_WIDTH  27

// jTLB set index, one VPN slice per page level
`define ARB_IDX_WIDTH  9

// bank select, one bit per jTLB way bank
`define ARB_BANK_WIDTH 4

// valid + vpn + 16-bit asid + page size + global
`define ARB_TAG_WIDTH  48

// 28-bit ppn + 14 flag bits
`define ARB_DATA_WIDTH 42

// one-hot page size: bit0 4K, bit1 2M, bit2 1G
`define ARB_PGS_WIDTH  3

// jTLB access type code
`define ARB_ACC_WIDTH  3

`endif

/* src/mmu_arb_pkg.sv */
//====================
// types for the jTLB arbiter: refill state and access opcodes
//====================
`include "mmu_arb_defines.svh"

package mmu_arb_pkg;

  //====================
  // refill tracking
  //====================
  // which requester owns an in-flight refill
  typedef enum logic [1:0] {
    ARB_IDLE  = 2'b00,
    ARB_IUTLB = 2'b01,
    ARB_DUTLB = 2'b10,
    ARB_PFU   = 2'b11
  } arb_state_e;

  //====================
  // jTLB access types
  //====================
  // walk code is shared with parity clear
  // 3'b101 and 3'b111 unused
  typedef enum logic [`ARB_ACC_WIDTH-1:0] {
    ACC_WALK    = 3'b000,
    ACC_TLBOPER = 3'b001,
    ACC_LOAD    = 3'b010,
    ACC_IFETCH  = 3'b011,
    ACC_PFU     = 3'b100,
    ACC_STORE   = 3'b110
  } jtlb_acc_e;

endpackage

/* src/arb_grant_if.sv */
//====================
// per-requester grant levels, driven by the priority logic
//====================
`timescale 1ns/1ns

interface arb_grant_if;

  // uTLB / prefetch winners
  logic pfu_grant;
  logic iutlb_grant;
  logic dutlb_grant;
  // maintenance and walker winners
  logic tlboper_grant;
  logic ptw_grant;
  // jTLB self requests
  logic read_huge;
  logic par_clr;

  // source side
  modport prio (
    output pfu_grant, iutlb_grant, dutlb_grant, tlboper_grant,
    output ptw_grant, read_huge, par_clr
  );

  // refill tracker only watches uTLB, prefetch and tlboper wins
  modport fsm (
    input pfu_grant, iutlb_grant, dutlb_grant, tlboper_grant
  );

  // steering needs every winner
  modport dp (
    input pfu_grant, iutlb_grant, dutlb_grant, tlboper_grant,
    input ptw_grant, read_huge, par_clr
  );

endinterface

/* src/arb_grant_prio.sv */
//====================
// fixed-priority pick among jTLB requesters, same-cycle grants
//====================
`timescale 1ns/1ns

module arb_grant_prio (
  input  logic             iutlb_req,
  input  logic             dutlb_req,
  input  logic             tlboper_req,
  input  logic             ptw_req,
  input  logic             va2_vld,
  input  logic             mmu_off,
  input  logic             sel_4k,
  input  logic             sel_2m,
  input  logic             sel_1g,
  input  logic             tc_miss,
  input  logic             par_clr_in,
  input  logic             utlb_mask,
  arb_grant_if.prio        grant,
  output logic             jtlb_req
);

  //====================
  // priority chain
  //====================
  // walker always wins, never masked
  assign grant.ptw_grant = ptw_req;

  // tlboper waits for walker, and only starts on a 4K select
  assign grant.tlboper_grant = tlboper_req && !ptw_req && sel_4k;

  // uTLB side blocked while a refill or tlboper is in flight
  assign grant.dutlb_grant = dutlb_req && !tlboper_req && !ptw_req && !utlb_mask;

  // instruction side yields to data side
  assign grant.iutlb_grant = iutlb_req && !dutlb_req && !tlboper_req
                          && !ptw_req && !utlb_mask;

  // prefetch lowest, and meaningless with translation off
  assign grant.pfu_grant = va2_vld && !mmu_off
                        && !iutlb_req && !dutlb_req
                        && !tlboper_req && !ptw_req
                        && !utlb_mask;

  //====================
  // jTLB self requests
  //====================
  // huge page hit on a tag-compare miss, re-read the entry
  assign grant.read_huge = (sel_2m || sel_1g) && tc_miss;

  // parity fail, invalidate the entry
  assign grant.par_clr = par_clr_in;

  // one request strobe for any winner
  assign jtlb_req = grant.pfu_grant
                 || grant.iutlb_grant
                 || grant.dutlb_grant
                 || grant.tlboper_grant
                 || grant.ptw_grant
                 || grant.read_huge
                 || grant.par_clr;

endmodule

/* src/arb_refill_fsm.sv */
//====================
// refill ownership FSM and tlboper busy flag
// produce the uTLB mask, walker mask and no-op level
//====================
`timescale 1ns/1ns

module arb_refill_fsm (
  input  logic      arb_clk,
  input  logic      cpurst_b,
  arb_grant_if.fsm  grant,
  input  logic      iutlb_cmplt,
  input  logic      dutlb_cmplt,
  input  logic      pfu_cmplt,
  input  logic      tlboper_cmplt,
  input  logic      no_op_req,
  output logic      utlb_mask,
  output logic      ptw_mask,
  output logic      no_op
);

  import mmu_arb_pkg::*;

  arb_state_e cur_st;
  arb_state_e nxt_st;
  logic       tlboper_on;
  logic       refill_on;

  //====================
  // refill FSM
  //====================
  always_ff @(posedge arb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_st <= ARB_IDLE;
    else
      cur_st <= nxt_st;
  end

  // open-ended refill ended only by the owner's cmplt
  always_comb
  begin
    nxt_st = cur_st;
    case (cur_st)
      ARB_IDLE:
      begin
        if (grant.pfu_grant)
          nxt_st = ARB_PFU;
        else if (grant.iutlb_grant)
          nxt_st = ARB_IUTLB;
        else if (grant.dutlb_grant)
          nxt_st = ARB_DUTLB;
      end
      ARB_IUTLB:
        if (iutlb_cmplt)
          nxt_st = ARB_IDLE;
      ARB_DUTLB:
        if (dutlb_cmplt)
          nxt_st = ARB_IDLE;
      ARB_PFU:
        if (pfu_cmplt)
          nxt_st = ARB_IDLE;
      default:
        nxt_st = ARB_IDLE;
    endcase
  end

  //====================
  // tlboper busy
  //====================
  // clear wins over a same-cycle set
  always_ff @(posedge arb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      tlboper_on <= 1'b0;
    else if (tlboper_on && tlboper_cmplt)
      tlboper_on <= 1'b0;
    else if (grant.tlboper_grant)
      tlboper_on <= 1'b1;
  end

  assign refill_on = (cur_st != ARB_IDLE);

  // uTLB and prefetch held off by either activity
  assign utlb_mask = refill_on || tlboper_on;
  // walker told to hold off while a maintenance op runs
  assign ptw_mask  = tlboper_on;
  // no-op only acknowledged with no refill pending
  assign no_op     = no_op_req && !refill_on;

endmodule

/* src/arb_jtlb_datapath.sv */
//====================
// steer the winning requester's fields onto the jTLB request
//====================
`timescale 1ns/1ns
`include "mmu_arb_defines.svh"

module arb_jtlb_datapath (
  arb_grant_if.dp                       grant,
  input  logic [`ARB_VPN_WIDTH-1:0]     iutlb_vpn, dutlb_vpn, pfu_vpn,
  input  logic [`ARB_VPN_WIDTH-1:0]     jtlb_vpn, tlboper_vpn, ptw_vpn,
  input  logic                          dutlb_load,
  input  logic [`ARB_IDX_WIDTH-1:0]     tlboper_idx,
  input  logic                          tlboper_idx_not_va,
  input  logic [`ARB_BANK_WIDTH-1:0]    tlboper_bank_sel, ptw_bank_sel,
  input  logic                          tlboper_write, tlboper_cmp_va, jtlb_cmp_va,
  input  logic [`ARB_ACC_WIDTH-1:0]     jtlb_type,
  input  logic [`ARB_PGS_WIDTH-1:0]     tlboper_pgs, ptw_pgs,
  input  logic                          tlboper_pgs_en, sel_4k, sel_2m, sel_1g,
  input  logic [`ARB_TAG_WIDTH-1:0]     tlboper_tag_din, ptw_tag_din,
  input  logic [`ARB_DATA_WIDTH-1:0]    tlboper_data_din, ptw_data_din,
  output logic [`ARB_VPN_WIDTH-1:0]     vpn_out,
  output logic [`ARB_IDX_WIDTH-1:0]     idx_out,
  output logic [`ARB_BANK_WIDTH-1:0]    bank_sel_out,
  output logic                          write_out,
  output logic                          cmp_with_va,
  output mmu_arb_pkg::jtlb_acc_e        acc_type,
  output logic [`ARB_TAG_WIDTH-1:0]     tag_din,
  output logic [`ARB_DATA_WIDTH-1:0]    data_din
);

  import mmu_arb_pkg::*;

  localparam int VW = `ARB_VPN_WIDTH;
  localparam int IW = `ARB_IDX_WIDTH;
  localparam int AW = `ARB_ACC_WIDTH;

  logic          jtlb_self;
  logic          lookup;
  logic          idx_4k, idx_2m, idx_1g;
  logic [IW-1:0] va_idx;
  logic          load_grant, store_grant;
  logic [AW-1:0] acc_bits;
  logic          tlboper_wen;

  //====================
  // vpn and index
  //====================
  // re-read and parity clear both replay the jTLB's own vpn
  assign jtlb_self = grant.read_huge || grant.par_clr;

  assign vpn_out = {VW{grant.pfu_grant}}     & pfu_vpn
                 | {VW{grant.iutlb_grant}}   & iutlb_vpn
                 | {VW{grant.dutlb_grant}}   & dutlb_vpn
                 | {VW{jtlb_self}}           & jtlb_vpn
                 | {VW{grant.tlboper_grant}} & tlboper_vpn
                 | {VW{grant.ptw_grant}}     & ptw_vpn;

  // page level for the set index
  // par_clr walks one level up: 2M->4K, 1G->2M, neither->1G
  assign idx_4k = tlboper_pgs_en  ? tlboper_pgs[0] :
                  grant.ptw_grant ? ptw_pgs[0]     :
                  grant.par_clr   ? sel_2m         : sel_4k;
  assign idx_2m = tlboper_pgs_en  ? tlboper_pgs[1] :
                  grant.ptw_grant ? ptw_pgs[1]     :
                  grant.par_clr   ? sel_1g         : sel_2m;
  assign idx_1g = tlboper_pgs_en  ? tlboper_pgs[2] :
                  grant.ptw_grant ? ptw_pgs[2]     :
                  grant.par_clr   ? (!sel_2m && !sel_1g) : sel_1g;

  assign va_idx = {IW{idx_4k}} & vpn_out[IW-1:0]
                | {IW{idx_2m}} & vpn_out[2*IW-1:IW]
                | {IW{idx_1g}} & vpn_out[3*IW-1:2*IW];

  // indexed tlb ops bypass the va
  assign idx_out = (grant.tlboper_grant && tlboper_idx_not_va) ? tlboper_idx : va_idx;

  //====================
  // bank, write, compare
  //====================
  assign lookup = grant.pfu_grant || grant.iutlb_grant || grant.dutlb_grant || jtlb_self;

  // lookups hit every bank
  assign bank_sel_out = {`ARB_BANK_WIDTH{lookup}}
                      | {`ARB_BANK_WIDTH{grant.tlboper_grant}} & tlboper_bank_sel
                      | {`ARB_BANK_WIDTH{grant.ptw_grant}}     & ptw_bank_sel;

  assign tlboper_wen = grant.tlboper_grant && tlboper_write;
  assign write_out   = tlboper_wen || grant.ptw_grant || grant.par_clr;

  assign cmp_with_va = grant.pfu_grant || grant.iutlb_grant || grant.dutlb_grant
                    || (grant.read_huge && jtlb_cmp_va)
                    || (grant.tlboper_grant && tlboper_cmp_va);

  //====================
  // access type
  //====================
  assign load_grant  = grant.dutlb_grant && dutlb_load;
  assign store_grant = grant.dutlb_grant && !dutlb_load;

  // walk and parity clear both encode as zero
  assign acc_bits = {AW{grant.pfu_grant}}     & ACC_PFU
                  | {AW{grant.iutlb_grant}}   & ACC_IFETCH
                  | {AW{load_grant}}          & ACC_LOAD
                  | {AW{store_grant}}         & ACC_STORE
                  | {AW{grant.tlboper_grant}} & ACC_TLBOPER
                  | {AW{grant.read_huge}}     & jtlb_type;
  assign acc_type = jtlb_acc_e'(acc_bits);

  //====================
  // tag and data words
  //====================
  assign tag_din  = {`ARB_TAG_WIDTH{tlboper_wen}}      & tlboper_tag_din
                  | {`ARB_TAG_WIDTH{grant.ptw_grant}}  & ptw_tag_din;
  assign data_din = {`ARB_DATA_WIDTH{tlboper_wen}}     & tlboper_data_din
                  | {`ARB_DATA_WIDTH{grant.ptw_grant}} & ptw_data_din;

endmodule

/* src/mmu_arb_top.sv */
//====================
// jTLB request arbiter top, plain ports toward MMU blocks
//====================
`timescale 1ns/1ns
`include "mmu_arb_defines.svh"

module mmu_arb_top (
  input  logic                        arb_clk,
  input  logic                        cpurst_b,
  // requests and completes
  input  logic                        iutlb_arb_req, dutlb_arb_req,
  input  logic                        tlboper_arb_req, ptw_arb_req,
  input  logic                        lsu_mmu_va2_vld, dutlb_xx_mmu_off,
  input  logic                        iutlb_arb_cmplt, dutlb_arb_cmplt,
  input  logic                        jtlb_arb_pfu_cmplt, tlboper_xx_cmplt,
  input  logic                        cp0_mmu_no_op_req,
  // jTLB status
  input  logic                        jtlb_arb_sel_4k, jtlb_arb_sel_2m, jtlb_arb_sel_1g,
  input  logic                        jtlb_arb_tc_miss, jtlb_arb_par_clr, jtlb_arb_cmp_va,
  input  logic [`ARB_ACC_WIDTH-1:0]   jtlb_arb_type,
  // per-requester payload
  input  logic [`ARB_VPN_WIDTH-1:0]   iutlb_arb_vpn, dutlb_arb_vpn, jtlb_arb_pfu_vpn,
  input  logic [`ARB_VPN_WIDTH-1:0]   jtlb_arb_vpn, tlboper_arb_vpn, ptw_arb_vpn,
  input  logic                        dutlb_arb_load,
  input  logic [`ARB_IDX_WIDTH-1:0]   tlboper_arb_idx,
  input  logic                        tlboper_arb_idx_not_va,
  input  logic [`ARB_BANK_WIDTH-1:0]  tlboper_arb_bank_sel, ptw_arb_bank_sel,
  input  logic                        tlboper_arb_write, tlboper_arb_cmp_va,
  input  logic [`ARB_PGS_WIDTH-1:0]   tlboper_xx_pgs, ptw_arb_pgs,
  input  logic                        tlboper_xx_pgs_en,
  input  logic [`ARB_TAG_WIDTH-1:0]   tlboper_arb_tag_din, ptw_arb_tag_din,
  input  logic [`ARB_DATA_WIDTH-1:0]  tlboper_arb_data_din, ptw_arb_data_din,
  // grants back to requesters
  output logic                        arb_pfu_grant, arb_iutlb_grant, arb_dutlb_grant,
  output logic                        arb_tlboper_grant, arb_ptw_grant,
  output logic                        arb_ptw_mask, mmu_yy_xx_no_op,
  // jTLB request
  output logic                        arb_jtlb_req,
  output logic [`ARB_VPN_WIDTH-1:0]   arb_jtlb_vpn,
  output logic [`ARB_IDX_WIDTH-1:0]   arb_jtlb_idx,
  output logic [`ARB_BANK_WIDTH-1:0]  arb_jtlb_bank_sel,
  output logic                        arb_jtlb_write, arb_jtlb_cmp_with_va,
  output logic [`ARB_ACC_WIDTH-1:0]   arb_jtlb_acc_type,
  output logic [`ARB_TAG_WIDTH-1:0]   arb_jtlb_tag_din,
  output logic [`ARB_DATA_WIDTH-1:0]  arb_jtlb_data_din
);

  logic utlb_mask;

  arb_grant_if u_grant ();

  // grant levels out to the requesters
  assign arb_pfu_grant     = u_grant.pfu_grant;
  assign arb_iutlb_grant   = u_grant.iutlb_grant;
  assign arb_dutlb_grant   = u_grant.dutlb_grant;
  assign arb_tlboper_grant = u_grant.tlboper_grant;
  assign arb_ptw_grant     = u_grant.ptw_grant;

  //====================
  // control
  //====================
  arb_grant_prio u_prio (
    .iutlb_req   (iutlb_arb_req),    .dutlb_req  (dutlb_arb_req),
    .tlboper_req (tlboper_arb_req),  .ptw_req    (ptw_arb_req),
    .va2_vld     (lsu_mmu_va2_vld),  .mmu_off    (dutlb_xx_mmu_off),
    .sel_4k      (jtlb_arb_sel_4k),  .sel_2m     (jtlb_arb_sel_2m),
    .sel_1g      (jtlb_arb_sel_1g),  .tc_miss    (jtlb_arb_tc_miss),
    .par_clr_in  (jtlb_arb_par_clr), .utlb_mask  (utlb_mask),
    .grant       (u_grant),          .jtlb_req   (arb_jtlb_req)
  );

  arb_refill_fsm u_fsm (
    .arb_clk       (arb_clk),            .cpurst_b    (cpurst_b),
    .grant         (u_grant),            .iutlb_cmplt (iutlb_arb_cmplt),
    .dutlb_cmplt   (dutlb_arb_cmplt),    .pfu_cmplt   (jtlb_arb_pfu_cmplt),
    .tlboper_cmplt (tlboper_xx_cmplt),   .no_op_req   (cp0_mmu_no_op_req),
    .utlb_mask     (utlb_mask),          .ptw_mask    (arb_ptw_mask),
    .no_op         (mmu_yy_xx_no_op)
  );

  //====================
  // datapath
  //====================
  arb_jtlb_datapath u_dp (
    .grant            (u_grant),
    .iutlb_vpn        (iutlb_arb_vpn),        .dutlb_vpn        (dutlb_arb_vpn),
    .pfu_vpn          (jtlb_arb_pfu_vpn),     .jtlb_vpn         (jtlb_arb_vpn),
    .tlboper_vpn      (tlboper_arb_vpn),      .ptw_vpn          (ptw_arb_vpn),
    .dutlb_load       (dutlb_arb_load),       .tlboper_idx      (tlboper_arb_idx),
    .tlboper_idx_not_va (tlboper_arb_idx_not_va),
    .tlboper_bank_sel (tlboper_arb_bank_sel), .ptw_bank_sel     (ptw_arb_bank_sel),
    .tlboper_write    (tlboper_arb_write),    .tlboper_cmp_va   (tlboper_arb_cmp_va),
    .jtlb_cmp_va      (jtlb_arb_cmp_va),      .jtlb_type        (jtlb_arb_type),
    .tlboper_pgs      (tlboper_xx_pgs),       .tlboper_pgs_en   (tlboper_xx_pgs_en),
    .ptw_pgs          (ptw_arb_pgs),          .sel_4k           (jtlb_arb_sel_4k),
    .sel_2m           (jtlb_arb_sel_2m),      .sel_1g           (jtlb_arb_sel_1g),
    .tlboper_tag_din  (tlboper_arb_tag_din),  .tlboper_data_din (tlboper_arb_data_din),
    .ptw_tag_din      (ptw_arb_tag_din),      .ptw_data_din     (ptw_arb_data_din),
    .vpn_out          (arb_jtlb_vpn),         .idx_out          (arb_jtlb_idx),
    .bank_sel_out     (arb_jtlb_bank_sel),    .write_out        (arb_jtlb_write),
    .cmp_with_va      (arb_jtlb_cmp_with_va), .acc_type         (arb_jtlb_acc_type),
    .tag_din          (arb_jtlb_tag_din),     .data_din         (arb_jtlb_data_din)
  );

endmodule

/* tests/mmu_arb_sva.sv */
//====================
// bound checks on the refill FSM, grants and masks
//====================
`timescale 1ns/1ns

module mmu_arb_sva (
  input logic       arb_clk,
  input logic       cpurst_b,
  input logic       pfu_grant,
  input logic       iutlb_grant,
  input logic       dutlb_grant,
  input logic       tlboper_grant,
  input logic       tlboper_cmplt,
  input logic [1:0] cur_st,
  input logic       tlboper_on,
  input logic       ptw_mask
);

  import mmu_arb_pkg::*;

  //====================
  // grants
  //====================
  // uTLB and prefetch winners never overlap
  a_refill_grant_onehot: assert property (
    @(posedge arb_clk) disable iff (!cpurst_b)
    $onehot0({pfu_grant, iutlb_grant, dutlb_grant})
  ) else $error("more than one refill grant high");

  //====================
  // FSM and masks
  //====================
  // FSM sits idle once reset releases
  a_idle_after_reset: assert property (
    @(posedge arb_clk)
    $rose(cpurst_b) |-> (cur_st == ARB_IDLE)
  ) else $error("refill FSM not idle after reset");

  // walker mask rises the cycle after a tlboper win
  a_ptw_mask_set: assert property (
    @(posedge arb_clk) disable iff (!cpurst_b)
    (!tlboper_on && tlboper_grant) |=> ptw_mask
  ) else $error("ptw_mask not raised after tlboper grant");

  // and drops the cycle after the tlboper completes
  a_ptw_mask_clr: assert property (
    @(posedge arb_clk) disable iff (!cpurst_b)
    (tlboper_on && tlboper_cmplt) |=> !ptw_mask
  ) else $error("ptw_mask not dropped after tlboper complete");

endmodule

// attach to every refill FSM
bind arb_refill_fsm mmu_arb_sva u_sva (
  .arb_clk       (arb_clk),
  .cpurst_b      (cpurst_b),
  .pfu_grant     (grant.pfu_grant),
  .iutlb_grant   (grant.iutlb_grant),
  .dutlb_grant   (grant.dutlb_grant),
  .tlboper_grant (grant.tlboper_grant),
  .tlboper_cmplt (tlboper_cmplt),
  .cur_st        (cur_st),
  .tlboper_on    (tlboper_on),
  .ptw_mask      (ptw_mask)
);

/* tests/mmu_arb_tb.sv */
//====================
// replays golden vectors into the jTLB arbiter one line per cycle
//====================
`timescale 1ns/1ns
`include "mmu_arb_defines.svh"

module mmu_arb_tb;

  // per-requester vpn with distinct 1G/2M/4K slices
  localparam logic [26:0] IU_VPN = 27'h0442413;
  localparam logic [26:0] DU_VPN = 27'h0844423;
  localparam logic [26:0] PF_VPN = 27'h0c46433;
  localparam logic [26:0] JT_VPN = 27'h1048443;
  localparam logic [26:0] TO_VPN = 27'h144a453;
  localparam logic [26:0] PT_VPN = 27'h184c463;
  localparam int MAXV = 64;

  logic arb_clk, cpurst_b;
  logic iu_req, du_req, to_req, pt_req, va2, moff, iu_c, du_c, pf_c, to_c, noop_req;
  logic s4k, s2m, s1g, tcm, pclr, jcmp, du_load, to_inv, to_wr, to_cmp, to_pen;
  logic [2:0]  jtype, to_pgs, pt_pgs;
  logic [47:0] to_tag, pt_tag;
  logic [41:0] to_data, pt_data;
  logic pfu_g, iu_g, du_g, to_g, pt_g, pmask, noop, jreq, wr, cmp;
  logic [26:0] vpn;
  logic [8:0]  idx;
  logic [3:0]  bank;
  logic [2:0]  acc;
  logic [47:0] tag;
  logic [41:0] data;

  // golden columns
  logic [31:0] v_test[MAXV], v_req[MAXV], v_cmpl[MAXV], v_jt[MAXV], v_tcfg[MAXV];
  logic [31:0] v_ppgs[MAXV], v_egr[MAXV], v_acc[MAXV], v_vpn[MAXV], v_idx[MAXV];
  logic [31:0] v_bank[MAXV];
  int nvec, limit, cycles, errors, checks, t_err, t_chk, ntests;
  logic [31:0] seed;

  mmu_arb_top DUT (
    .arb_clk(arb_clk), .cpurst_b(cpurst_b),
    .iutlb_arb_req(iu_req), .dutlb_arb_req(du_req), .tlboper_arb_req(to_req),
    .ptw_arb_req(pt_req), .lsu_mmu_va2_vld(va2), .dutlb_xx_mmu_off(moff),
    .iutlb_arb_cmplt(iu_c), .dutlb_arb_cmplt(du_c), .jtlb_arb_pfu_cmplt(pf_c),
    .tlboper_xx_cmplt(to_c), .cp0_mmu_no_op_req(noop_req),
    .jtlb_arb_sel_4k(s4k), .jtlb_arb_sel_2m(s2m), .jtlb_arb_sel_1g(s1g),
    .jtlb_arb_tc_miss(tcm), .jtlb_arb_par_clr(pclr), .jtlb_arb_cmp_va(jcmp),
    .jtlb_arb_type(jtype), .iutlb_arb_vpn(IU_VPN), .dutlb_arb_vpn(DU_VPN),
    .jtlb_arb_pfu_vpn(PF_VPN), .jtlb_arb_vpn(JT_VPN), .tlboper_arb_vpn(TO_VPN),
    .ptw_arb_vpn(PT_VPN), .dutlb_arb_load(du_load), .tlboper_arb_idx(9'h1ab),
    .tlboper_arb_idx_not_va(to_inv), .tlboper_arb_bank_sel(4'h5),
    .ptw_arb_bank_sel(4'h3), .tlboper_arb_write(to_wr), .tlboper_arb_cmp_va(to_cmp),
    .tlboper_xx_pgs(to_pgs), .ptw_arb_pgs(pt_pgs), .tlboper_xx_pgs_en(to_pen),
    .tlboper_arb_tag_din(to_tag), .ptw_arb_tag_din(pt_tag),
    .tlboper_arb_data_din(to_data), .ptw_arb_data_din(pt_data),
    .arb_pfu_grant(pfu_g), .arb_iutlb_grant(iu_g), .arb_dutlb_grant(du_g),
    .arb_tlboper_grant(to_g), .arb_ptw_grant(pt_g), .arb_ptw_mask(pmask),
    .mmu_yy_xx_no_op(noop), .arb_jtlb_req(jreq), .arb_jtlb_vpn(vpn),
    .arb_jtlb_idx(idx), .arb_jtlb_bank_sel(bank), .arb_jtlb_write(wr),
    .arb_jtlb_cmp_with_va(cmp), .arb_jtlb_acc_type(acc),
    .arb_jtlb_tag_din(tag), .arb_jtlb_data_din(data)
  );

  always #10 arb_clk = ~arb_clk;

  // watchdog against the limit set once vectors are loaded
  always @(posedge arb_clk)
  begin
    cycles = cycles + 1;
    if (cycles >= limit)
    begin
      $display("timeout: run still going after %0d cycles", limit);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic load_golden();
    int fd, n;
    string line;
    fd = $fopen("tests/mmu_arb_golden.txt", "r");
    nvec = 0;
    if (fd == 0)
      $display("could not open the golden vector file");
    while (fd != 0 && !$feof(fd) && nvec < MAXV)
    begin
      line = "";
      n = $fgets(line, fd);
      // skip comments and blank lines
      if (line.len() > 4 && line.getc(0) != "#")
      begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", v_test[nvec], v_req[nvec],
                    v_cmpl[nvec], v_jt[nvec], v_tcfg[nvec], v_ppgs[nvec], v_egr[nvec],
                    v_acc[nvec], v_vpn[nvec], v_idx[nvec], v_bank[nvec]);
        if (n == 11)
          nvec = nvec + 1;
      end
    end
    if (fd != 0)
      $fclose(fd);
  endtask

  task automatic drive_vector(input int i);
    {du_load, noop_req, moff, va2, pt_req, to_req, du_req, iu_req} = v_req[i][7:0];
    {to_c, pf_c, du_c, iu_c} = v_cmpl[i][3:0];
    {jtype, jcmp, pclr, tcm, s1g, s2m, s4k} = v_jt[i][8:0];
    {to_pgs, to_pen, to_inv, to_cmp, to_wr} = v_tcfg[i][6:0];
    pt_pgs = v_ppgs[i][2:0];
    // fresh random words every cycle
    seed = xorshift(seed);
    to_tag = {seed, 16'h0} | {32'h0, seed[31:16]};
    to_data = {seed[9:0], 32'h0} | {10'h0, ~seed};
    seed = xorshift(seed);
    pt_tag = {seed[15:0], seed};
    pt_data = {seed[31:22], seed ^ 32'h5a5a5a5a};
  endtask

  task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks = checks + 1;
    t_chk = t_chk + 1;
    if (got !== exp)
    begin
      $display("** Error at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      errors = errors + 1;
      t_err = t_err + 1;
    end
  endtask

  task automatic check_vector(input int i);
    logic [9:0]  eg;
    logic [47:0] etag;
    logic [41:0] edata;
    eg = v_egr[i][9:0];
    // tag/data come from a tlboper write or a walk and are zero otherwise
    etag = 48'h0;
    edata = 42'h0;
    if (eg[3] && v_tcfg[i][0])
    begin
      etag = to_tag;
      edata = to_data;
    end
    else if (eg[4])
    begin
      etag = pt_tag;
      edata = pt_data;
    end
    check_field("grants", {54'h0, cmp, wr, noop, pmask, jreq, pt_g, to_g, du_g, iu_g, pfu_g},
                {54'h0, eg});
    check_field("acc_type", {61'h0, acc}, {61'h0, v_acc[i][2:0]});
    check_field("vpn", {37'h0, vpn}, {37'h0, v_vpn[i][26:0]});
    check_field("idx", {55'h0, idx}, {55'h0, v_idx[i][8:0]});
    check_field("bank_sel", {60'h0, bank}, {60'h0, v_bank[i][3:0]});
    check_field("tag_din", {16'h0, tag}, {16'h0, etag});
    check_field("data_din", {22'h0, data}, {22'h0, edata});
  endtask

  task automatic report_test(input logic [31:0] num);
    $display("test %0d finished: %0d checks, %0d errors", num, t_chk, t_err);
    ntests = ntests + 1;
    t_chk = 0;
    t_err = 0;
  endtask

  initial
  begin
    arb_clk = 0;
    cpurst_b = 0;
    seed = 32'hc3b7;
    cycles = 0;
    limit = 100000;
    errors = 0;
    checks = 0;
    t_err = 0;
    t_chk = 0;
    ntests = 0;
    {du_load, noop_req, moff, va2, pt_req, to_req, du_req, iu_req} = 8'h0;
    {to_c, pf_c, du_c, iu_c} = 4'h0;
    {jtype, jcmp, pclr, tcm, s1g, s2m, s4k} = 9'h001;
    {to_pgs, to_pen, to_inv, to_cmp, to_wr} = 7'h0;
    pt_pgs = 3'h1;
    to_tag = '0;
    pt_tag = '0;
    to_data = '0;
    pt_data = '0;
    load_golden();
    limit = nvec + 10 + 20;
    if (nvec == 0)
    begin
      $display("no golden vectors were loaded");
      errors = errors + 1;
    end
    repeat (10) @(posedge arb_clk);
    #2 cpurst_b = 1;
    for (int i = 0; i < nvec; i++)
    begin
      @(posedge arb_clk);
      #2 drive_vector(i);
      #17 check_vector(i);
      if (i == nvec - 1 || v_test[i + 1] != v_test[i])
        report_test(v_test[i]);
    end
    $display("%0d tests, %0d checks, %0d errors", ntests, checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* tests/mmu_arb_golden.txt */
# test req cmpl jt tcfg ptw_pgs | exp_grants exp_acc exp_vpn exp_idx exp_bank
# req: ld,noop,off,va2,ptw,tlbop,dutlb,iutlb  grants: cmp,wr,noop,pmask,jreq,ptw,tlbop,du,iu,pfu
1 9f 0 001 00 1 130 0 184c463 063 3
1 97 0 001 00 1 028 1 144a453 053 5
1 93 8 001 00 1 040 0 0000000 000 0
1 93 0 001 00 1 224 2 0844423 023 f
1 91 2 001 00 1 000 0 0000000 000 0
1 91 0 001 00 1 222 3 0442413 013 f
1 10 1 001 00 1 000 0 0000000 000 0
1 10 0 001 00 1 221 4 0c46433 033 f
1 00 4 001 00 1 000 0 0000000 000 0
2 41 0 001 00 1 2a2 3 0442413 013 f
2 53 0 001 00 1 000 0 0000000 000 0
2 53 0 001 00 1 000 0 0000000 000 0
2 53 1 001 00 1 000 0 0000000 000 0
2 53 0 001 00 1 2a4 6 0844423 023 f
2 40 2 001 00 1 000 0 0000000 000 0
2 40 0 001 00 1 080 0 0000000 000 0
3 04 0 001 03 1 328 1 144a453 053 5
3 11 0 001 00 1 040 0 0000000 000 0
3 09 0 001 00 2 170 0 184c463 062 3
3 01 8 001 00 1 040 0 0000000 000 0
3 01 0 001 00 1 222 3 0442413 013 f
3 00 1 001 00 1 000 0 0000000 000 0
3 00 0 001 00 1 000 0 0000000 000 0
4 82 0 002 00 1 224 2 0844423 022 f
4 00 2 001 00 1 000 0 0000000 000 0
4 01 0 004 00 1 222 3 0442413 011 f
4 00 1 001 00 1 000 0 0000000 000 0
4 04 0 001 04 1 028 1 144a453 1ab 5
4 00 8 001 00 1 040 0 0000000 000 0
4 04 0 001 28 1 028 1 144a453 052 5
4 00 8 001 00 1 040 0 0000000 000 0
4 00 0 012 00 1 120 0 1048443 043 f
4 00 0 014 00 1 120 0 1048443 042 f
4 00 0 011 00 1 120 0 1048443 041 f
4 00 0 0aa 00 1 220 2 1048443 042 f
5 04 0 001 01 1 128 1 144a453 053 5
5 00 8 001 00 1 040 0 0000000 000 0
5 08 0 001 00 4 130 0 184c463 061 3
5 30 0 001 00 1 000 0 0000000 000 0
5 00 0 012 00 1 120 0 1048443 043 f
5 00 0 001 00 1 000 0 0000000 000 0

/* sim.f */
+incdir+src
src/mmu_arb_pkg.sv
src/arb_grant_if.sv
src/arb_grant_prio.sv
src/arb_refill_fsm.sv
src/arb_jtlb_datapath.sv
src/mmu_arb_top.sv
tests/mmu_arb_sva.sv
tests/mmu_arb_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the jTLB arbiter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing \
  --top-module mmu_arb_tb \
  -f sim.f \
  -o mmu_arb_sim

./obj_dir/mmu_arb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

if ! grep -q "Verification passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"
